// File: dv/buck_control_tb.sv
// Buck controller testbench
// Drives the control core through reset, start, update and stop, and
// checks the PWM duty, the phase spacing and the running and busy flags
// against values worked out from the drawn setpoints.

`timescale 1ns/1ns
`default_nettype none

module buck_control_tb
    import buck_setpoint_pkg::*;
;

    localparam int n_phases    = 4;
    localparam int cycle_limit = 6000;

    logic                clock = 1'b0;
    logic                reset;
    logic                start;
    logic                stop;
    logic                update;
    setpoint_t           setpoint;
    logic [n_phases-1:0] pwm;
    logic                running;
    logic                busy;

    int    error_count = 0;
    int    tests_run = 0;
    int    tests_passed = 0;
    int    errors_at_start = 0;
    int    cycle_count = 0;
    string test_name;
    logic  hold_running = 1'b0;
    logic  hold_stopped = 1'b0;

    logic [n_phases-1:0] trace [0:255];
    int                  trace_len;

    buck_control_top #(
        .n_phases     (n_phases),
        .buffer_depth (2)
    ) dut (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .stop     (stop),
        .update   (update),
        .setpoint (setpoint),
        .pwm      (pwm),
        .running  (running),
        .busy     (busy)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions that hold while a test says so
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!reset) hold_running |-> running)
        else begin
            $display("Running dropped while the converter should stay on");
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!reset)
        hold_stopped |-> (pwm == '0 && !running && !busy))
        else begin
            $display("The stopped converter showed pwm, running or busy activity");
            error_count++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
            else begin
                $display("[ERROR] %s (%s): expected %0d, actual %0d",
                         test_name, name, expected, actual);
                error_count++;
            end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", test_name);
        end else begin
            $display("FAIL  %s", test_name);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    // Period 16 to 63; duty at least 1 so that every phase has a rising edge
    function automatic setpoint_t draw_setpoint();
        setpoint_t sp;
        int        period;
        sp        = '0;
        period    = 16 + int'($urandom % 48);
        sp.period = 16'(period);
        for (int k = 0; k < n_phases; k++) begin
            sp.duty[k]  = 16'(1 + int'($urandom % (period - 1)));
            sp.shift[k] = 16'(int'($urandom % period));
        end
        return sp;
    endfunction

    task automatic capture_trace(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clock);
            #1;
            trace[i] = pwm;
        end
        trace_len = n;
    endtask

    function automatic int high_count(input int k, input int first, input int len);
        int total;
        total = 0;
        for (int i = first; i < first + len; i++) begin
            if (trace[i][k]) begin
                total++;
            end
        end
        return total;
    endfunction

    function automatic int first_rise(input int k, input int from);
        for (int i = from; i < trace_len; i++) begin
            if (trace[i][k] && !trace[i-1][k]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_duties(input string name, input setpoint_t sp);
        int period;
        period = int'(sp.period);
        capture_trace(3 * period);
        for (int k = 0; k < n_phases; k++) begin
            check_value($sformatf("%s high count phase %0d", name, k),
                        int'(sp.duty[k]), high_count(k, 0, period));
        end
    endtask

    // Phase k rises when the carrier reaches its shift
    task automatic check_edges(input string name, input setpoint_t sp);
        int period;
        int r0;
        int rk;
        period = int'(sp.period);
        r0     = first_rise(0, 1);
        assert (r0 > 0)
            else begin
                $display("%s: phase 0 showed no rising edge", name);
                error_count++;
            end
        if (r0 > 0) begin
            for (int k = 1; k < n_phases; k++) begin
                rk = first_rise(k, r0);
                check_value($sformatf("%s edge delay phase %0d", name, k),
                            (int'(sp.shift[k]) - int'(sp.shift[0]) + period) % period,
                            rk - r0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        setpoint_t first_sp;
        setpoint_t second_sp;
        int        waited;

        reset    = 1'b0;
        start    = 1'b0;
        stop     = 1'b0;
        update   = 1'b0;
        setpoint = '0;
        void'($urandom(14950));

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;

        begin_test("reset");
        wait_cycles(1);
        check_value("reset pwm", 0, int'(pwm));
        check_value("reset running", 0, int'(running));
        check_value("reset busy", 0, int'(busy));
        end_test();

        begin_test("start duty");
        first_sp = draw_setpoint();
        setpoint = first_sp;
        start    = 1'b1;
        wait_cycles(1);
        start  = 1'b0;
        waited = 0;
        while (!running && waited < 19) begin
            wait_cycles(1);
            waited++;
        end
        assert (running)
            else begin
                $display("Running did not rise within 20 cycles of start");
                error_count++;
            end
        hold_running = 1'b1;
        wait_cycles(4);
        check_duties("start", first_sp);
        end_test();

        begin_test("phase spacing");
        check_edges("start", first_sp);
        end_test();

        begin_test("update while running");
        second_sp = draw_setpoint();
        setpoint  = second_sp;
        update    = 1'b1;
        wait_cycles(1);
        update = 1'b0;
        waited = 0;
        while (!busy && waited < 4) begin
            wait_cycles(1);
            waited++;
        end
        assert (busy)
            else begin
                $display("The update was not taken by the sequencer");
                error_count++;
            end
        waited = 0;
        while (busy && waited < 20) begin
            wait_cycles(1);
            waited++;
        end
        assert (!busy)
            else begin
                $display("The update sequence did not finish within 20 cycles");
                error_count++;
            end
        wait_cycles(4);
        check_duties("update", second_sp);
        check_edges("update", second_sp);
        end_test();

        begin_test("stop");
        hold_running = 1'b0;
        stop         = 1'b1;
        wait_cycles(1);
        stop   = 1'b0;
        waited = 0;
        while (running && waited < 3) begin
            wait_cycles(1);
            waited++;
        end
        assert (!running)
            else begin
                $display("Running did not fall within 4 cycles of stop");
                error_count++;
            end
        wait_cycles(3);
        hold_stopped = 1'b1;
        wait_cycles(2 * int'(second_sp.period));
        end_test();

        begin_test("update while stopped");
        setpoint = draw_setpoint();
        update   = 1'b1;
        wait_cycles(1);
        update = 1'b0;
        wait_cycles(40);
        hold_stopped = 1'b0;
        end_test();

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/buck_setpoint_pkg.sv
source/buck_register_map_pkg.sv
source/buck_command_latch.sv
source/buck_operating_sequencer.sv
source/pwm_register_bank.sv
source/pwm_phase_generator.sv
source/buck_control_top.sv
dv/buck_control_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the buck controller testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module buck_control_tb \
    -f files.f -o buck_control_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/buck_control_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// File: source/buck_command_latch.sv
// Buck controller command latch
// Holds start, stop and update requests as levels until the operating
// sequencer takes them, and captures the setpoint snapshot that the
// sequencer reads while it writes the registers.

`timescale 1ns/1ns
`default_nettype none

module buck_command_latch
    import buck_setpoint_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  logic      stop,
    input  logic      update,
    input  setpoint_t setpoint_in,
    input  logic      running,
    input  logic      busy,
    input  logic      request_taken,
    output logic      start_request,
    output logic      stop_request,
    output logic      update_request,
    output setpoint_t snapshot
);

    logic accept_update;

    // An update only makes sense while the modulator is on
    assign accept_update = update && running;

    always_ff @(posedge clock) begin
        if (!reset) begin
            start_request  <= 1'b0;
            stop_request   <= 1'b0;
            update_request <= 1'b0;
        end else begin
            // The sequencer takes one request and the rest are stale,
            // but anything raised in this same cycle survives
            if (request_taken) begin
                start_request  <= 1'b0;
                stop_request   <= 1'b0;
                update_request <= 1'b0;
            end
            if (start) begin
                start_request <= 1'b1;
            end
            if (stop) begin
                stop_request <= 1'b1;
            end
            if (accept_update) begin
                update_request <= 1'b1;
            end
        end
    end

    // The snapshot stays stable while a register sequence is running
    always_ff @(posedge clock) begin
        if (!busy && (start || accept_update)) begin
            snapshot <= setpoint_in;
        end
    end

endmodule

`default_nettype wire

// File: source/buck_control_top.sv
// Buck converter control core
// Command latch, operating sequencer, PWM register bank and phase
// generator for a multi-phase interleaved buck converter.

`timescale 1ns/1ns
`default_nettype none

module buck_control_top
    import buck_setpoint_pkg::*;
    import buck_register_map_pkg::*;
#(
    parameter int n_phases     = 4,
    parameter int buffer_depth = 2
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic                stop,
    input  logic                update,
    input  setpoint_t           setpoint,
    output logic [n_phases-1:0] pwm,
    output logic                running,
    output logic                busy
);

    logic                                  start_request;
    logic                                  stop_request;
    logic                                  update_request;
    logic                                  request_taken;
    setpoint_t                             snapshot;
    logic                                  write_valid;
    reg_write_t                            write;
    logic                                  credit_return;
    logic [timing_width-1:0]               active_period;
    logic [n_phases-1:0][timing_width-1:0] active_duty;
    logic [n_phases-1:0][timing_width-1:0] active_shift;
    logic                                  enable;

    buck_command_latch command_latch (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .stop           (stop),
        .update         (update),
        .setpoint_in    (setpoint),
        .running        (running),
        .busy           (busy),
        .request_taken  (request_taken),
        .start_request  (start_request),
        .stop_request   (stop_request),
        .update_request (update_request),
        .snapshot       (snapshot)
    );

    buck_operating_sequencer #(
        .n_phases     (n_phases),
        .buffer_depth (buffer_depth)
    ) sequencer (
        .clock          (clock),
        .reset          (reset),
        .start_request  (start_request),
        .stop_request   (stop_request),
        .update_request (update_request),
        .snapshot       (snapshot),
        .credit_return  (credit_return),
        .write_valid    (write_valid),
        .write          (write),
        .request_taken  (request_taken),
        .running        (running),
        .busy           (busy)
    );

    pwm_register_bank #(
        .n_phases     (n_phases),
        .buffer_depth (buffer_depth)
    ) register_bank (
        .clock         (clock),
        .reset         (reset),
        .write_valid   (write_valid),
        .write         (write),
        .credit_return (credit_return),
        .active_period (active_period),
        .active_duty   (active_duty),
        .active_shift  (active_shift),
        .enable        (enable)
    );

    pwm_phase_generator #(
        .n_phases (n_phases)
    ) phase_generator (
        .clock         (clock),
        .reset         (reset),
        .active_period (active_period),
        .active_duty   (active_duty),
        .active_shift  (active_shift),
        .enable        (enable),
        .pwm           (pwm)
    );

endmodule

`default_nettype wire

// File: source/buck_operating_sequencer.sv
// Buck controller operating sequencer
// Turns start, update and stop requests into register writes for the
// PWM register bank. A start or update walks the phases writing all
// periods, then all phase shifts, then all duties; a start then enables
// the modulator. A stop issues a single disable write. Writes are limited
// by credits that the bank returns as its buffer drains.

`timescale 1ns/1ns
`default_nettype none

module buck_operating_sequencer
    import buck_setpoint_pkg::*;
    import buck_register_map_pkg::*;
#(
    parameter int n_phases     = 4,
    parameter int buffer_depth = 2
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       start_request,
    input  logic       stop_request,
    input  logic       update_request,
    input  setpoint_t  snapshot,
    input  logic       credit_return,
    output logic       write_valid,
    output reg_write_t write,
    output logic       request_taken,
    output logic       running,
    output logic       busy
);

    localparam int credit_width = $clog2(buffer_depth + 1);

    typedef enum logic [2:0] {
        idle,
        write_period,
        write_shift,
        write_duty,
        write_control
    } state_t;

    state_t                  state;
    logic [2:0]              phase;
    logic [credit_width-1:0] credits;
    logic                    start_needed;
    logic                    last_phase;

    ////////////////////////////////////////////////////////////////////////////
    // Request handshake and write issue
    ////////////////////////////////////////////////////////////////////////////

    assign busy          = (state != idle);
    assign request_taken = !busy && (start_request || stop_request || update_request);
    assign last_phase    = (phase == 3'(n_phases - 1));

    // No credit means the buffer may be full, so nothing goes out
    assign write_valid = busy && (credits != '0);

    always_comb begin
        write       = '0;
        write.phase = phase;
        case (state)
            write_period: begin
                write.select     = sel_period;
                write.data.timing = snapshot.period;
            end
            write_shift: begin
                write.select     = sel_phase_shift;
                write.data.timing = snapshot.shift[phase];
            end
            write_duty: begin
                write.select     = sel_duty;
                write.data.timing = snapshot.duty[phase];
            end
            default: begin
                write.select                   = sel_control;
                write.data.control.enable      = start_needed;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence FSM and credit counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= idle;
            phase        <= '0;
            credits      <= credit_width'(buffer_depth);
            start_needed <= 1'b0;
            running      <= 1'b0;
        end else begin
            case ({write_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            case (state)
                idle: begin
                    // Stop wins over anything else that is pending
                    if (stop_request) begin
                        start_needed <= 1'b0;
                        state        <= write_control;
                    end else if (start_request) begin
                        start_needed <= 1'b1;
                        state        <= write_period;
                    end else if (update_request && running) begin
                        start_needed <= 1'b0;
                        state        <= write_period;
                    end
                end
                write_period: begin
                    if (write_valid) begin
                        phase <= last_phase ? 3'd0 : phase + 1'b1;
                        if (last_phase) begin
                            state <= write_shift;
                        end
                    end
                end
                write_shift: begin
                    if (write_valid) begin
                        phase <= last_phase ? 3'd0 : phase + 1'b1;
                        if (last_phase) begin
                            state <= write_duty;
                        end
                    end
                end
                write_duty: begin
                    if (write_valid) begin
                        phase <= last_phase ? 3'd0 : phase + 1'b1;
                        // An update leaves the modulator as it is
                        if (last_phase) begin
                            state <= start_needed ? write_control : idle;
                        end
                    end
                end
                write_control: begin
                    if (write_valid) begin
                        running <= start_needed;
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/buck_register_map_pkg.sv
// Buck controller register map
// Register select codes and the write word that the operating sequencer
// sends to the PWM register bank. The data field carries either a timing
// value or a control word, depending on the register select.

`default_nettype none

package buck_register_map_pkg;

    // Register select, the low part of the compact register address
    typedef enum logic [1:0] {
        sel_period      = 2'd0,
        sel_phase_shift = 2'd1,
        sel_duty        = 2'd2,
        sel_control     = 2'd3
    } reg_select_t;

    // Modulator control word; only the enable bit has a meaning for now
    typedef struct packed {
        logic        enable;
        logic [14:0] reserved;
    } control_word_t;

    // One data word with two readings, chosen by the register select
    typedef union packed {
        logic [15:0]   timing;
        control_word_t control;
    } reg_word_u;

    // Register write: phase index, register select and data
    typedef struct packed {
        logic [2:0]  phase;
        reg_select_t select;
        reg_word_u   data;
    } reg_write_t;

endpackage

`default_nettype wire

// File: source/buck_setpoint_pkg.sv
// Buck controller setpoint definitions
// Timing width and the setpoint snapshot that the input side hands to
// the operating sequencer. The struct is sized for the largest phase
// count and the upper phases are unused on smaller builds.

`default_nettype none

package buck_setpoint_pkg;

    // Width of period, duty and phase shift values
    localparam int timing_width = 16;

    // Largest phase count a setpoint can describe
    localparam int max_phases = 8;

    // Period is shared by all phases, duty and shift are per phase
    typedef struct packed {
        logic [timing_width-1:0]                 period;
        logic [max_phases-1:0][timing_width-1:0] duty;
        logic [max_phases-1:0][timing_width-1:0] shift;
    } setpoint_t;

endpackage

`default_nettype wire

// File: source/pwm_phase_generator.sv
// PWM phase generator
// One carrier counter shared by all phases. Each phase compares the
// carrier, shifted back by its phase shift and wrapped at the period,
// against its duty. Outputs are registered and held low while the
// modulator is disabled.

`timescale 1ns/1ns
`default_nettype none

module pwm_phase_generator
    import buck_setpoint_pkg::*;
#(
    parameter int n_phases = 4
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [timing_width-1:0]               active_period,
    input  logic [n_phases-1:0][timing_width-1:0] active_duty,
    input  logic [n_phases-1:0][timing_width-1:0] active_shift,
    input  logic                                  enable,
    output logic [n_phases-1:0]                   pwm
);

    logic [timing_width-1:0]               carrier;
    logic [n_phases-1:0][timing_width-1:0] offset;

    // Carrier position seen by each phase, modulo the period
    always_comb begin
        for (int k = 0; k < n_phases; k++) begin
            if (carrier >= active_shift[k]) begin
                offset[k] = carrier - active_shift[k];
            end else begin
                offset[k] = carrier + active_period - active_shift[k];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            carrier <= '0;
            pwm     <= '0;
        end else begin
            // The >= also catches a carrier left above a shorter new period
            if (!enable || carrier >= active_period - 1'b1) begin
                carrier <= '0;
            end else begin
                carrier <= carrier + 1'b1;
            end
            for (int k = 0; k < n_phases; k++) begin
                pwm[k] <= enable && (offset[k] < active_duty[k]);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_register_bank.sv
// PWM register bank
// Buffers register writes in a small FIFO and drains one entry per cycle
// into the active timing registers and the modulator enable. Each drained
// entry returns one credit to the sequencer.

`timescale 1ns/1ns
`default_nettype none

module pwm_register_bank
    import buck_setpoint_pkg::*;
    import buck_register_map_pkg::*;
#(
    parameter int n_phases     = 4,
    parameter int buffer_depth = 2
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  write_valid,
    input  reg_write_t                            write,
    output logic                                  credit_return,
    output logic [timing_width-1:0]               active_period,
    output logic [n_phases-1:0][timing_width-1:0] active_duty,
    output logic [n_phases-1:0][timing_width-1:0] active_shift,
    output logic                                  enable
);

    localparam int ptr_width   = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
    localparam int count_width = $clog2(buffer_depth + 1);

    reg_write_t             buffer [buffer_depth];
    logic [ptr_width-1:0]   write_ptr;
    logic [ptr_width-1:0]   read_ptr;
    logic [count_width-1:0] count;
    reg_write_t             head;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(buffer_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Any stored entry is drained right away
    assign credit_return = (count != '0);
    assign head          = buffer[read_ptr];

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
            enable    <= 1'b0;
        end else begin
            if (write_valid) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (credit_return) begin
                read_ptr <= next_ptr(read_ptr);
            end
            case ({write_valid, credit_return})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (credit_return && head.select == sel_control) begin
                enable <= head.data.control.enable;
            end
        end
    end

    // Buffer storage and the timing registers it feeds
    always_ff @(posedge clock) begin
        if (write_valid) begin
            buffer[write_ptr] <= write;
        end
        if (credit_return) begin
            case (head.select)
                sel_period:      active_period <= head.data.timing;
                sel_phase_shift: active_shift[head.phase] <= head.data.timing;
                sel_duty:        active_duty[head.phase] <= head.data.timing;
                default:         ;
            endcase
        end
    end

endmodule

`default_nettype wire
